//--- src/spram_pkg.sv
// spram tile shared definitions
`default_nettype none

package spram_pkg;

    // macro geometry, fixed by the hard cell
    localparam int MACRO_WIDTH = 8; // bits per macro word
    localparam int MACRO_AW    = 6; // 64 rows per macro

    // one byte lane of data or mask
    typedef logic [MACRO_WIDTH-1:0] lane_t;

    // row address inside one macro
    typedef logic [MACRO_AW-1:0] macro_addr_t;

    // request presented to one macro, active-high strobes
    typedef struct packed {
        logic        ce;    // macro enable
        logic        we;    // write when set, read otherwise
        macro_addr_t row;   // row inside macro
        lane_t       din;   // write data slice
        lane_t       wmask; // per-bit write mask slice
    } lane_req_t;

endpackage

`default_nettype wire

//--- src/spram_bank_decode.sv
// spram bank address decode
`timescale 1ns/1ps
`default_nettype none

module spram_bank_decode #(
    parameter int AW = 10 // word address width
) (
    input  logic                    ce,        // chip enable
    input  logic                    we,        // write enable
    input  logic [AW-1:0]           addr,      // word address
    output logic [((AW > spram_pkg::MACRO_AW) ? (1 << (AW - spram_pkg::MACRO_AW)) : 1)-1:0]
                                    bank_en,   // one-hot bank enable
    output logic                    we_q,      // write gated by ce
    output spram_pkg::macro_addr_t  row,       // row inside each macro
    output logic [((AW > spram_pkg::MACRO_AW) ? (AW - spram_pkg::MACRO_AW) : 1)-1:0]
                                    rd_bank,   // bank of this access
    output logic                    rd_strobe  // read this cycle
);

    localparam int BANK_BITS = (AW > spram_pkg::MACRO_AW) ? AW - spram_pkg::MACRO_AW : 0;
    localparam int BW        = (BANK_BITS > 0) ? BANK_BITS : 1; // index width, min 1

    logic [BW-1:0] bank_idx; // upper address bits

    generate
        if (BANK_BITS > 0) begin : g_split
            assign row      = addr[spram_pkg::MACRO_AW-1:0]; // low bits pick the row
            assign bank_idx = addr[AW-1:spram_pkg::MACRO_AW]; // high bits pick the bank
        end else begin : g_single
            assign row      = spram_pkg::macro_addr_t'(addr); // zero-extend short address
            assign bank_idx = '0; // only one bank
        end
    endgenerate

    always_comb begin
        bank_en = '0;
        if (ce) begin
            bank_en[bank_idx] = 1'b1; // gate ce into the addressed bank
        end
    end

    assign we_q      = ce & we; // no write intent without an access
    assign rd_strobe = ce & ~we;
    assign rd_bank   = bank_idx;

    // one bank per access, read and write strobes exclusive
    a_bank_en_onehot: assert property (@(bank_en)
        $onehot0(bank_en) && ((|bank_en) == (we_q | rd_strobe)) && !(we_q && rd_strobe))
        else $error("bank_en not one-hot or out of step with the access strobes");

endmodule

`default_nettype wire

//--- src/spram_macro_model.sv
// behavioral 8-bit sram macro
`timescale 1ns/1ps
`default_nettype none

module spram_macro_model (
    input  logic                  clk,
    input  spram_pkg::lane_req_t  req, // active-high request from the array
    output spram_pkg::lane_t      q    // registered read data
);

    localparam int ROWS = 1 << spram_pkg::MACRO_AW; // 64 rows

    spram_pkg::lane_t mem [ROWS]; // cell contents, not reset

    // cell pins are active low
    logic             cen;  // chip enable, low active
    logic             gwen; // global write enable, low active
    spram_pkg::lane_t wen;  // bit write enables, low active

    assign cen  = ~req.ce;
    assign gwen = ~req.we;
    assign wen  = ~req.wmask;

    // write port, bitwise under wen
    always_ff @(posedge clk) begin
        if (!cen && !gwen) begin
            for (int b = 0; b < spram_pkg::MACRO_WIDTH; b++) begin
                if (!wen[b]) begin
                    mem[req.row][b] <= req.din[b]; // masked-off bits keep old value
                end
            end
        end
    end

    // read port, q holds through writes and idle cycles
    always_ff @(posedge clk) begin
        if (!cen && gwen) begin
            q <= mem[req.row];
        end
    end

endmodule

`default_nettype wire

//--- src/spram_array.sv
// spram macro tile array
`timescale 1ns/1ps
`default_nettype none

module spram_array #(
    parameter int DW = 32, // data width
    parameter int AW = 10  // word address width
) (
    input  logic                                   clk,
    input  logic                                   rst,     // assertion disable only
    input  logic [((AW > spram_pkg::MACRO_AW) ? (1 << (AW - spram_pkg::MACRO_AW)) : 1)-1:0]
                                                   bank_en, // one-hot bank enable
    input  logic                                   we,      // write, already ce-gated
    input  spram_pkg::macro_addr_t                 row,     // row inside each macro
    input  logic [DW-1:0]                          din,     // write data
    input  logic [DW-1:0]                          wmask,   // per-bit write mask
    output logic [((AW > spram_pkg::MACRO_AW) ? (1 << (AW - spram_pkg::MACRO_AW)) : 1)
                  * ((DW + 7) / 8) * 8 - 1:0]      macro_q  // all macro outputs, flat
);

    localparam int MW        = spram_pkg::MACRO_WIDTH;
    localparam int NUM_LANES = (DW + MW - 1) / MW; // ceil of DW/8
    localparam int NUM_BANKS = (AW > spram_pkg::MACRO_AW) ? 1 << (AW - spram_pkg::MACRO_AW) : 1;

    logic [NUM_LANES-1:0][MW-1:0] din_lane;  // data cut into lanes
    logic [NUM_LANES-1:0][MW-1:0] mask_lane; // mask cut into lanes

    genvar b, l, i;
    generate
        // slice into byte lanes, pad the top of the last lane
        for (l = 0; l < NUM_LANES; l++) begin : g_lane
            for (i = 0; i < MW; i++) begin : g_bit
                if (l * MW + i < DW) begin : g_used
                    assign din_lane[l][i]  = din[l*MW+i];
                    assign mask_lane[l][i] = wmask[l*MW+i];
                end else begin : g_pad
                    assign din_lane[l][i]  = 1'b0;
                    assign mask_lane[l][i] = 1'b0; // padded bits never written
                end
            end
        end

        // one macro per bank and lane
        for (b = 0; b < NUM_BANKS; b++) begin : g_bank
            for (l = 0; l < NUM_LANES; l++) begin : g_col
                spram_pkg::lane_req_t req;

                assign req.ce    = bank_en[b];
                assign req.we    = we & bank_en[b]; // write only in the enabled bank
                assign req.row   = row;
                assign req.din   = din_lane[l];
                assign req.wmask = mask_lane[l];

                spram_macro_model i_macro (
                    .clk (clk),
                    .req (req),
                    .q   (macro_q[(b*NUM_LANES+l)*MW +: MW])
                );
            end
        end
    endgenerate

    // decode gates we with ce, so a write always lands in exactly one bank
    a_write_has_bank: assert property (@(posedge clk) disable iff (rst)
        we |-> $onehot(bank_en))
        else $error("write with no bank enabled");

endmodule

`default_nettype wire

//--- src/spram_read_merge.sv
// spram read data merge
`timescale 1ns/1ps
`default_nettype none

module spram_read_merge #(
    parameter int DW = 32, // data width
    parameter int AW = 10  // word address width
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   rd_strobe, // read issued this cycle
    input  logic [((AW > spram_pkg::MACRO_AW) ? (AW - spram_pkg::MACRO_AW) : 1)-1:0]
                                                   rd_bank,   // bank of the read
    input  logic [((AW > spram_pkg::MACRO_AW) ? (1 << (AW - spram_pkg::MACRO_AW)) : 1)
                  * ((DW + 7) / 8) * 8 - 1:0]      macro_q,   // all macro outputs
    output logic [DW-1:0]                          dout,      // merged read word
    output logic                                   rvalid     // one pulse per read
);

    localparam int MW        = spram_pkg::MACRO_WIDTH;
    localparam int NUM_LANES = (DW + MW - 1) / MW;
    localparam int PW        = NUM_LANES * MW; // padded word width
    localparam int BW        = (AW > spram_pkg::MACRO_AW) ? AW - spram_pkg::MACRO_AW : 1;

    logic [BW-1:0] bank_q; // bank captured with the last read
    logic [PW-1:0] word;   // padded word from that bank

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bank_q <= '0;
        end else begin
            rvalid <= rd_strobe; // q is valid the cycle after the read
            if (rd_strobe) begin
                bank_q <= rd_bank; // later writes elsewhere do not move the mux
            end
        end
    end

    assign word = macro_q[bank_q*PW +: PW];
    assign dout = word[DW-1:0]; // drop lane padding

    // no read means no rvalid and the merged word holds
    a_hold_without_read: assert property (@(posedge clk) disable iff (rst)
        !rd_strobe |=> !rvalid && (dout === $past(dout)))
        else $error("rvalid or dout changed without a preceding read");

endmodule

`default_nettype wire

//--- src/spram_tile_top.sv
// spram tiled memory top
`timescale 1ns/1ps
`default_nettype none

module spram_tile_top #(
    parameter int DW = 32, // data width, any width of 1 or more
    parameter int AW = 10  // word address width
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          ce,     // chip enable
    input  logic          we,     // write enable
    input  logic [AW-1:0] addr,   // word address
    input  logic [DW-1:0] din,    // write data
    input  logic [DW-1:0] wmask,  // per-bit write mask
    output logic [DW-1:0] dout,   // read data
    output logic          rvalid  // read data valid
);

    localparam int NUM_LANES = (DW + spram_pkg::MACRO_WIDTH - 1) / spram_pkg::MACRO_WIDTH;
    localparam int NUM_BANKS = (AW > spram_pkg::MACRO_AW) ? 1 << (AW - spram_pkg::MACRO_AW) : 1;
    localparam int BW        = (AW > spram_pkg::MACRO_AW) ? AW - spram_pkg::MACRO_AW : 1;

    logic [NUM_BANKS-1:0]                          bank_en;   // decode to array
    logic                                          we_q;      // ce-gated write
    spram_pkg::macro_addr_t                        row;       // macro row
    logic [BW-1:0]                                 rd_bank;   // read bank index
    logic                                          rd_strobe; // read this cycle
    logic [NUM_BANKS*NUM_LANES*spram_pkg::MACRO_WIDTH-1:0] macro_q; // raw macro outputs

    spram_bank_decode #(.AW(AW)) i_decode (
        .ce        (ce),
        .we        (we),
        .addr      (addr),
        .bank_en   (bank_en),
        .we_q      (we_q),
        .row       (row),
        .rd_bank   (rd_bank),
        .rd_strobe (rd_strobe)
    );

    spram_array #(.DW(DW), .AW(AW)) i_array (
        .clk     (clk),
        .rst     (rst),
        .bank_en (bank_en),
        .we      (we_q),
        .row     (row),
        .din     (din),
        .wmask   (wmask),
        .macro_q (macro_q)
    );

    spram_read_merge #(.DW(DW), .AW(AW)) i_merge (
        .clk       (clk),
        .rst       (rst),
        .rd_strobe (rd_strobe),
        .rd_bank   (rd_bank),
        .macro_q   (macro_q),
        .dout      (dout),
        .rvalid    (rvalid)
    );

endmodule

`default_nettype wire

//--- sim/tb_spram_tile.sv
// spram tile testbench
`timescale 1ns/1ps
`default_nettype none

module tb_spram_tile;

    localparam int DW      = 20;       // 3 lanes, last one padded
    localparam int AW      = 8;        // 4 banks of 64 rows
    localparam int DEPTH   = 1 << AW;
    localparam int TIMEOUT = 10;       // cycles to wait for rvalid

    logic          clk;
    logic          rst;
    logic          ce;
    logic          we;
    logic [AW-1:0] addr;
    logic [DW-1:0] din;
    logic [DW-1:0] wmask;
    logic [DW-1:0] dout;
    logic          rvalid;

    logic [DW-1:0] ref_mem [DEPTH]; // reference model of the array
    logic [31:0]   lcg_state;
    int            pass_cnt;
    int            fail_cnt;

    spram_tile_top #(.DW(DW), .AW(AW)) i_dut (
        .clk    (clk),
        .rst    (rst),
        .ce     (ce),
        .we     (we),
        .addr   (addr),
        .din    (din),
        .wmask  (wmask),
        .dout   (dout),
        .rvalid (rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // step past the next rising edge, inputs change here
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string msg);
        fail_cnt++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic write_word(input logic [AW-1:0] a, input logic [DW-1:0] d,
                              input logic [DW-1:0] m);
        ce    = 1'b1;
        we    = 1'b1;
        addr  = a;
        din   = d;
        wmask = m;
        ref_mem[a] = (ref_mem[a] & ~m) | (d & m); // masked bits take din
        next_cycle();
        ce = 1'b0;
        we = 1'b0;
    endtask

    // issue one read, wait for rvalid, compare with reference
    task automatic read_check(input logic [AW-1:0] a);
        int n;
        ce   = 1'b1;
        we   = 1'b0;
        addr = a;
        next_cycle();
        ce = 1'b0;
        n  = 0;
        while (rvalid !== 1'b1 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (rvalid !== 1'b1) begin
            fail_cnt++;
            $display("no rvalid within %0d cycles after the read of address %0d", TIMEOUT, a);
        end else if (n != 0) begin
            report_mismatch($sformatf("rvalid %0d cycles late for address %0d", n, a));
        end else if (dout !== ref_mem[a]) begin
            report_mismatch($sformatf("addr %0d dout %05h expected %05h", a, dout, ref_mem[a]));
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_hold(input logic [DW-1:0] held, input string tag);
        if (dout !== held || rvalid !== 1'b0) begin
            report_mismatch($sformatf("%s: dout %05h rvalid %b, expected %05h and 0",
                                      tag, dout, rvalid, held));
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (16) begin
            next_cycle();
            if (rvalid !== 1'b0) report_mismatch("rvalid high during reset");
            else pass_cnt++;
        end
        rst = 1'b0;
        next_cycle(); // first idle cycle out of reset
        if (rvalid !== 1'b0) report_mismatch("rvalid high after reset");
        else pass_cnt++;
        $display("test reset finished, %0d failures so far", fail_cnt);
    endtask

    task automatic test_all_banks();
        write_word(8'h00, 20'h1a2b3, '1); // bank 0 first row
        write_word(8'h3f, 20'hfedcb, '1); // bank 0 last row
        write_word(8'h45, 20'h5a5a5, '1); // bank 1
        write_word(8'h9a, 20'h0f0f0, '1); // bank 2
        write_word(8'hc0, 20'h8c3e1, '1); // bank 3 first row
        write_word(8'hff, 20'h7b19d, '1); // bank 3 last row
        read_check(8'h00);
        read_check(8'h3f);
        read_check(8'h45);
        read_check(8'h9a);
        read_check(8'hc0);
        read_check(8'hff);
        $display("test all banks finished, %0d failures so far", fail_cnt);
    endtask

    task automatic test_write_mask();
        write_word(8'h77, 20'hf0f0f, '1);
        write_word(8'h77, 20'h0a5c3, 20'haaaaa); // odd bits only
        read_check(8'h77);
        write_word(8'hb2, 20'h33cc3, '1);
        write_word(8'hb2, 20'hc1e96, 20'h55555); // even bits only
        read_check(8'hb2);
        $display("test write mask finished, %0d failures so far", fail_cnt);
    endtask

    task automatic test_hold();
        logic [DW-1:0] held;
        read_check(8'h45);
        held = ref_mem[8'h45]; // word the read returned
        repeat (3) begin
            next_cycle(); // idle
            check_hold(held, "idle");
        end
        write_word(8'hd0, 20'h12345, '1); // bank 3
        check_hold(held, "write other bank");
        write_word(8'h10, 20'h6789a, '1); // bank 0
        check_hold(held, "write other bank");
        ce    = 1'b0; // write strobe without enable
        we    = 1'b1;
        addr  = 8'h45;
        din   = ~held;
        wmask = '1;
        next_cycle();
        we = 1'b0;
        check_hold(held, "disabled write");
        read_check(8'h45); // reference left untouched
        read_check(8'hd0);
        $display("test hold finished, %0d failures so far", fail_cnt);
    endtask

    task automatic test_traffic();
        logic [AW-1:0] seq [4];
        logic [31:0]   r;
        logic [31:0]   d;
        logic [31:0]   m;
        seq[0] = 8'h00;
        seq[1] = 8'h45;
        seq[2] = 8'h9a;
        seq[3] = 8'hff;
        // one read per cycle, each answered on the next edge
        for (int i = 0; i < 4; i++) begin
            ce   = 1'b1;
            we   = 1'b0;
            addr = seq[i];
            next_cycle();
            if (rvalid !== 1'b1 || dout !== ref_mem[seq[i]]) begin
                report_mismatch($sformatf("back-to-back addr %0d dout %05h rvalid %b exp %05h",
                                          seq[i], dout, rvalid, ref_mem[seq[i]]));
            end else begin
                pass_cnt++;
            end
        end
        ce = 1'b0;
        // known contents everywhere before random reads
        for (int a = 0; a < DEPTH; a++) begin
            write_word(a[AW-1:0], {a[7:0] ^ 8'h3c, a[7:4] ^ a[3:0], a[7:0]}, '1);
        end
        for (int k = 0; k < 300; k++) begin
            r = next_rand();
            d = next_rand();
            m = next_rand();
            if (r[4:3] == 2'b00) begin
                ce   = 1'b0; // idle, sometimes with we set
                we   = r[5];
                addr = r[15:8];
                din  = d[DW-1:0];
                next_cycle();
                we = 1'b0;
                if (rvalid !== 1'b0) report_mismatch("rvalid high after idle cycle");
                else pass_cnt++;
            end else if (r[6]) begin
                write_word(r[15:8], d[DW-1:0], m[DW-1:0]);
            end else begin
                read_check(r[15:8]);
            end
        end
        $display("test traffic finished, %0d failures so far", fail_cnt);
    endtask

    initial begin
        rst       = 1'b1;
        ce        = 1'b0;
        we        = 1'b0;
        addr      = '0;
        din       = '0;
        wmask     = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        lcg_state = 32'h329e_aac4;
        test_reset();
        test_all_banks();
        test_write_mask();
        test_hold();
        test_traffic();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- spram_tile.f
src/spram_pkg.sv
src/spram_bank_decode.sv
src/spram_macro_model.sv
src/spram_array.sv
src/spram_read_merge.sv
src/spram_tile_top.sv
sim/tb_spram_tile.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_spram_tile -f spram_tile.f \
    && ./obj_dir/Vtb_spram_tile | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass line found" \
    || { echo "run_sim: build error or no pass line"; exit 1; }
